// ==== l1_cache.f ====
rtl/l1_cache_pkg.sv
rtl/cache_lookup.sv
rtl/cache_arrays.sv
rtl/cache_ctrl.sv
rtl/cache_respond.sv
rtl/l1_cache.sv
tests/mem_model.sv
tests/l1_cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the L1 data cache testbench
VERILATOR  := verilator
TOP        := l1_cache_tb
RTL_TOP    := l1_cache
FILELIST   := l1_cache.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/l1_cache_tb.sv ====
/* testbench for l1_cache with a small two-way geometry and a waiting memory
   test addresses stay within 4 KiB of 0 and of NONCACHE_START */
`timescale 1ns/1ns

module l1_cache_tb import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE     = 128,
    parameter int    BLOCK_SIZE     = 2,
    parameter int    ASSOC          = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000,
    parameter int    MEM_WAIT       = 2
) ();

    localparam int N_SETS     = CACHE_SIZE / 4 / BLOCK_SIZE / ASSOC;
    localparam int SET_STRIDE = N_SETS * BLOCK_SIZE * 4; // bytes between blocks of one set
    localparam int REF_SIZE   = 8192;

    typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_t;
    typedef struct {
        op_t                   op;
        word_t                 addr;
        word_t                 data; // check count for a flush
        logic [BYTE_LANES-1:0] be;
        word_t                 exp;  // read data or the word after an uncached store
    } entry_t;

    logic                   CLK, nRST, ren, wen, flush, busy, flush_done;
    word_t                  addr, wdata, rdata, mem_addr;
    logic [BYTE_LANES-1:0]  byte_en, mem_byte_en;
    logic                   mem_ren, mem_wen, mem_wait;
    word_t [BLOCK_SIZE-1:0] mem_wdata, mem_rdata;

    entry_t     ops[$];
    word_t      written_q[$]; // since the last flush entry
    word_t      chk_addr_q[$];
    word_t      chk_data_q[$];
    logic [7:0] ref_img [REF_SIZE];
    integer     seed;
    int         cycles = 0;
    int         cycle_limit;
    int         n_flush = 0;

    l1_cache #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC),
               .NONCACHE_START(NONCACHE_START)) u_dut (.*);

    mem_model #(.BLOCK_SIZE(BLOCK_SIZE), .WAIT_CYCLES(MEM_WAIT),
                .NONCACHE_START(NONCACHE_START)) u_mem (.*);

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the cache or memory never completed", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run hung");
        end
    end

    function automatic int ref_idx(input word_t a);
        return int'({a[31], a[11:0]});
    endfunction

    function automatic word_t ref_word(input word_t a);
        word_t w;
        for (int i = 0; i < BYTE_LANES; i++)
            w[8*i +: 8] = ref_img[ref_idx({a[31:2], 2'b00}) + i];
        return w;
    endfunction

    function automatic void add_read(input word_t a);
        ops.push_back('{OP_READ, a, 32'h0, 4'h0, ref_word(a)});
    endfunction

    function automatic void add_write(input word_t a, input word_t d, input logic [3:0] be);
        for (int i = 0; i < BYTE_LANES; i++)
            if (be[i])
                ref_img[ref_idx({a[31:2], 2'b00}) + i] = d[8*i +: 8];
        written_q.push_back({a[31:2], 2'b00});
        ops.push_back('{OP_WRITE, a, d, be, ref_word(a)});
    endfunction

    // memory must hold every word written so far once the flush is done
    function automatic void add_flush();
        foreach (written_q[i]) begin
            chk_addr_q.push_back(written_q[i]);
            chk_data_q.push_back(ref_word(written_q[i]));
        end
        ops.push_back('{OP_FLUSH, 32'h0, 32'(written_q.size()), 4'h0, 32'h0});
        written_q.delete();
        n_flush++;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp)
        else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic access(input entry_t e, output word_t rd);
        @(negedge CLK);
        ren     = e.op == OP_READ;
        wen     = e.op == OP_WRITE;
        addr    = e.addr;
        wdata   = e.data;
        byte_en = e.be;
        #1;
        while (busy) begin
            @(negedge CLK);
            #1;
        end
        rd = rdata; // request completes at the next rising edge
    endtask

    task automatic run_flush();
        @(negedge CLK);
        ren   = 1'b0;
        wen   = 1'b0;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        #1;
        while (!flush_done) begin
            @(negedge CLK);
            #1;
        end
        @(posedge CLK); // last write-back lands here
        #1;
        check_word("flush_done after its pulse", 32'h0, 32'(flush_done));
    endtask

    initial begin
        entry_t                e;
        word_t                 rd, a, w;
        logic [BYTE_LANES-1:0] rbe;
        int                    clear_cycles, chk_pos;
        seed    = 32'hbb15_c980;
        nRST    = 1'b0;
        ren     = 1'b0;
        wen     = 1'b0;
        flush   = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        for (int i = 0; i < REF_SIZE; i++) begin
            a          = {i[12], 19'h0, i[11:0]};
            w          = {a[31:2], 2'b00};
            w          = w ^ {w[15:0], w[31:16]} ^ 32'h3c5a_96e1; // memory power-up pattern
            ref_img[i] = w[8*a[1:0] +: 8];
        end

        // first touch of each block is a miss fill
        add_read(32'h000);
        add_read(32'h004);
        add_read(32'h010);
        add_read(32'h044);
        add_read(32'h100);
        add_write(32'h010, 32'h0000_00a5, 4'b0001);
        add_read(32'h010);
        add_write(32'h010, 32'hbeef_0000, 4'b1100);
        add_read(32'h010);
        add_write(32'h014, 32'h1234_5678, 4'b1111);
        add_write(32'h014, 32'h0000_9900, 4'b0010);
        add_read(32'h014);
        for (int i = 0; i < ASSOC + 2; i++) // more blocks than ways in set 0
            add_write(32'(i * SET_STRIDE), 32'hd00d_0000 + 32'(i), 4'b1111);
        for (int i = 0; i < ASSOC + 2; i++)
            add_read(32'(i * SET_STRIDE));
        add_flush();
        add_read(NONCACHE_START);
        add_write(NONCACHE_START, 32'h0000_5a00, 4'b0010);
        add_read(NONCACHE_START);
        add_write(NONCACHE_START + 4, 32'hc300_00c3, 4'b1001);
        add_read(NONCACHE_START + 4);
        add_write(NONCACHE_START + 8, 32'h7777_1111, 4'b1111);
        add_read(NONCACHE_START + 8);
        for (int i = 0; i < 200; i++) begin
            a   = word_t'($random(seed)) & 32'h0000_01fc; // 512 bytes or four cache sizes
            rbe = 4'($random(seed));
            if (rbe == 4'b0000)
                rbe = 4'b1111;
            if ($random(seed) & 1)
                add_write(a, word_t'($random(seed)), rbe);
            else
                add_read(a);
        end
        add_flush();
        cycle_limit = 10 + N_SETS * ASSOC + ops.size() * (2 * BLOCK_SIZE + 2 * MEM_WAIT + 10)
                    + n_flush * N_SETS * ASSOC * (MEM_WAIT + 2);

        repeat (10) @(negedge CLK);
        nRST         = 1'b1;
        clear_cycles = 0;
        #1;
        while (busy) begin
            check_word("{mem_ren, mem_wen, flush_done} during clear", 32'h0,
                       32'({mem_ren, mem_wen, flush_done}));
            @(negedge CLK);
            #1;
            clear_cycles++;
        end
        check_word("busy high cycles after reset", 32'(N_SETS * ASSOC), 32'(clear_cycles));

        chk_pos = 0;
        foreach (ops[i]) begin
            e = ops[i];
            if (e.op == OP_FLUSH) begin
                run_flush();
                for (int k = 0; k < int'(e.data); k++) begin
                    a = chk_addr_q[chk_pos];
                    check_word($sformatf("memory word at %h", a), chk_data_q[chk_pos],
                               u_mem.words[{a[31], a[11:2]}]);
                    chk_pos++;
                end
            end else begin
                access(e, rd);
                if (e.op == OP_READ) begin
                    check_word($sformatf("rdata at %h", e.addr), e.exp, rd);
                end else if (e.addr >= NONCACHE_START) begin
                    @(posedge CLK); // uncached store reaches the model here
                    #1;
                    a = e.addr;
                    check_word($sformatf("memory word at %h", a), e.exp,
                               u_mem.words[{a[31], a[11:2]}]);
                end
            end
        end

        @(negedge CLK);
        ren = 1'b0;
        wen = 1'b0;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tests/mem_model.sv ====
/* block memory model with a fixed wait count before every transfer
   4 KiB from address 0 and 4 KiB from NONCACHE_START are distinct, other addresses alias
   assumes NONCACHE_START has bit 31 set */
`timescale 1ns/1ns

module mem_model import l1_cache_pkg::*; #(
    parameter int    BLOCK_SIZE     = 2,
    parameter int    WAIT_CYCLES    = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  word_t                  mem_addr,
    input  word_t [BLOCK_SIZE-1:0] mem_wdata,
    input  logic [BYTE_LANES-1:0]  mem_byte_en,
    output word_t [BLOCK_SIZE-1:0] mem_rdata,
    output logic                   mem_wait
);

    word_t words [2048]; // upper half holds the uncached region
    int    wait_cnt;
    logic  req;

    function automatic int word_idx(input word_t a);
        return int'({a[31], a[11:2]});
    endfunction

    initial begin
        word_t a;
        for (int i = 0; i < 2048; i++) begin
            a        = {i[10], 19'h0, i[9:0], 2'b00};
            words[i] = a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
        end
    end

    assign req      = mem_ren || mem_wen;
    assign mem_wait = req && wait_cnt < WAIT_CYCLES;

    // word 0 is the addressed word for pass-through reads
    always_comb begin
        for (int k = 0; k < BLOCK_SIZE; k++)
            mem_rdata[k] = words[word_idx(mem_addr + 32'(4 * k))];
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST)
            wait_cnt <= 0;
        else if (req && mem_wait)
            wait_cnt <= wait_cnt + 1;
        else
            wait_cnt <= 0; // restart after each transfer
    end

    always @(posedge CLK) begin
        if (mem_wen && !mem_wait) begin
            if (mem_addr >= NONCACHE_START) begin
                for (int i = 0; i < BYTE_LANES; i++)
                    if (mem_byte_en[i])
                        words[word_idx(mem_addr)][8*i +: 8] <= mem_wdata[0][8*i +: 8];
            end else begin
                for (int k = 0; k < BLOCK_SIZE; k++)
                    words[word_idx(mem_addr + 32'(4 * k))] <= mem_wdata[k];
            end
        end
    end

endmodule

// ==== rtl/l1_cache.sv ====
/* write-back, write-allocate L1 data cache with NRU placement
   CACHE_SIZE and BLOCK_SIZE are powers of two, BLOCK_SIZE 2..8, ASSOC 1 or 2,
   and the geometry must give at least two sets */
`timescale 1ns/1ns

module l1_cache import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE     = 1024,
    parameter int    BLOCK_SIZE     = 2,
    parameter int    ASSOC          = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000
) (
    input  logic                   CLK,
    input  logic                   nRST,
    // processor side
    input  logic                   ren,
    input  logic                   wen,
    input  word_t                  addr,
    input  word_t                  wdata,
    input  logic [BYTE_LANES-1:0]  byte_en,
    input  logic                   flush,
    output logic                   busy,
    output word_t                  rdata,
    output logic                   flush_done,
    // memory side
    output logic                   mem_ren,
    output logic                   mem_wen,
    output word_t                  mem_addr,
    output word_t [BLOCK_SIZE-1:0] mem_wdata,
    output logic [BYTE_LANES-1:0]  mem_byte_en,
    input  word_t [BLOCK_SIZE-1:0] mem_rdata,
    input  logic                   mem_wait
);

    localparam int N_SETS = CACHE_SIZE / 4 / BLOCK_SIZE / ASSOC;
    localparam int SET_W  = $clog2(N_SETS);
    localparam int OFF_W  = $clog2(BLOCK_SIZE);
    localparam int WAY_W  = (ASSOC > 1) ? $clog2(ASSOC) : 1;
    localparam int TAG_W  = WORD_W - SET_W - OFF_W - 2;

    logic [SET_W-1:0]                  set_idx, sel_set;
    logic [TAG_W-1:0]                  tag, victim_tag, wr_tag;
    logic [OFF_W-1:0]                  word_sel;
    logic [WAY_W-1:0]                  hit_way, victim_way, touch_way, wr_way;
    logic                              hit, victim_dirty, pass_through;
    logic                              touch, ctrl_busy, write_hit;
    logic [ASSOC-1:0][TAG_W-1:0]       rd_tags;
    logic [ASSOC-1:0]                  rd_valid, rd_dirty;
    word_t [ASSOC-1:0][BLOCK_SIZE-1:0] rd_blocks;
    logic                              wr_en, wr_valid, wr_dirty, wr_word_only;
    word_t [BLOCK_SIZE-1:0]            wr_block;
    word_t                             merged_word, pass_store;

    cache_lookup #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC),
                   .NONCACHE_START(NONCACHE_START)) u_lookup (
        .CLK, .nRST, .addr,
        .way_tags(rd_tags), .way_valid(rd_valid), .way_dirty(rd_dirty),
        .touch, .touch_way, .set_idx, .tag, .word_sel, .hit, .hit_way,
        .victim_way, .victim_dirty, .victim_tag, .pass_through
    );

    cache_arrays #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)) u_arrays (
        .CLK, .nRST, .sel_set, .wr_en, .wr_way, .wr_valid, .wr_dirty, .wr_tag, .wr_block,
        .wr_word_only, .wr_word_idx(word_sel), .wr_word(merged_word),
        .rd_tags, .rd_valid, .rd_dirty, .rd_blocks
    );

    cache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)) u_ctrl (
        .CLK, .nRST, .ren, .wen, .flush, .addr, .hit, .hit_way, .victim_way, .victim_dirty,
        .victim_tag, .pass_through, .set_idx, .tag, .byte_en, .write_hit, .pass_store,
        .rd_valid, .rd_dirty, .rd_tags, .rd_blocks, .mem_rdata, .mem_wait,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en, .sel_set,
        .wr_en, .wr_way, .wr_valid, .wr_dirty, .wr_tag, .wr_block, .wr_word_only,
        .touch, .touch_way, .ctrl_busy, .flush_done
    );

    cache_respond #(.BLOCK_SIZE(BLOCK_SIZE)) u_respond (
        .ren, .wen, .hit, .pass_through, .ctrl_busy,
        .hit_block(rd_blocks[hit_way]), .word_sel, .wdata, .byte_en,
        .old_word(rd_blocks[hit_way][word_sel]), .mem_rdata0(mem_rdata[0]), .mem_wait,
        .busy, .rdata, .merged_word, .pass_store, .write_hit
    );

endmodule

// ==== rtl/cache_respond.sv ====
/* processor response, write-hit byte merge and pass-through store lanes
   busy is combinational on hit and mem_wait */
`timescale 1ns/1ns

module cache_respond import l1_cache_pkg::*; #(
    parameter int  BLOCK_SIZE = 2,
    localparam int OFF_W      = $clog2(BLOCK_SIZE)
) (
    input  logic                   ren,
    input  logic                   wen,
    input  logic                   hit,
    input  logic                   pass_through,
    input  logic                   ctrl_busy,
    input  word_t [BLOCK_SIZE-1:0] hit_block,
    input  logic [OFF_W-1:0]       word_sel,
    input  word_t                  wdata,
    input  logic [BYTE_LANES-1:0]  byte_en,
    input  word_t                  old_word,
    input  word_t                  mem_rdata0,
    input  logic                   mem_wait,
    output logic                   busy,
    output word_t                  rdata,
    output word_t                  merged_word,
    output word_t                  pass_store,
    output logic                   write_hit
);

    logic req;

    assign req       = ren || wen;
    assign busy      = ctrl_busy || (req && (pass_through ? mem_wait : !hit));
    assign write_hit = wen && hit && !ctrl_busy;

    always_comb begin
        if (!ren)
            rdata = '0;
        else if (pass_through)
            rdata = mem_rdata0; // straight from the bus
        else
            rdata = hit_block[word_sel];
    end

    // enabled lanes take wdata
    always_comb begin
        for (int i = 0; i < BYTE_LANES; i++) begin
            merged_word[8*i +: 8] = byte_en[i] ? wdata[8*i +: 8] : old_word[8*i +: 8];
            pass_store[8*i +: 8]  = byte_en[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

endmodule

// ==== rtl/cache_ctrl.sv ====
/* cache controller FSM, memory bus drive and array write commands
   memory requests are held until mem_wait is low, the state holds meanwhile */
`timescale 1ns/1ns

module cache_ctrl import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    parameter int  ASSOC      = 2,
    localparam int N_SETS = CACHE_SIZE / 4 / BLOCK_SIZE / ASSOC,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int OFF_W  = $clog2(BLOCK_SIZE),
    localparam int WAY_W  = (ASSOC > 1) ? $clog2(ASSOC) : 1,
    localparam int TAG_W  = WORD_W - SET_W - OFF_W - 2
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              ren,
    input  logic                              wen,
    input  logic                              flush,
    input  word_t                             addr,
    input  logic                              hit,
    input  logic [WAY_W-1:0]                  hit_way,
    input  logic [WAY_W-1:0]                  victim_way,
    input  logic                              victim_dirty,
    input  logic [TAG_W-1:0]                  victim_tag,
    input  logic                              pass_through,
    input  logic [SET_W-1:0]                  set_idx,
    input  logic [TAG_W-1:0]                  tag,
    input  logic [BYTE_LANES-1:0]             byte_en,
    input  logic                              write_hit,
    input  word_t                             pass_store,
    input  logic [ASSOC-1:0]                  rd_valid,
    input  logic [ASSOC-1:0]                  rd_dirty,
    input  logic [ASSOC-1:0][TAG_W-1:0]       rd_tags,
    input  word_t [ASSOC-1:0][BLOCK_SIZE-1:0] rd_blocks,
    input  word_t [BLOCK_SIZE-1:0]            mem_rdata,
    input  logic                              mem_wait,
    output logic                              mem_ren,
    output logic                              mem_wen,
    output word_t                             mem_addr,
    output word_t [BLOCK_SIZE-1:0]            mem_wdata,
    output logic [BYTE_LANES-1:0]             mem_byte_en,
    output logic [SET_W-1:0]                  sel_set,
    output logic                              wr_en,
    output logic [WAY_W-1:0]                  wr_way,
    output logic                              wr_valid,
    output logic                              wr_dirty,
    output logic [TAG_W-1:0]                  wr_tag,
    output word_t [BLOCK_SIZE-1:0]            wr_block,
    output logic                              wr_word_only,
    output logic                              touch,
    output logic [WAY_W-1:0]                  touch_way,
    output logic                              ctrl_busy,
    output logic                              flush_done
);

    cache_state_t     state, next_state;
    logic [SET_W-1:0] fl_set; // walk position, shared by CLEAR and FLUSH
    logic [WAY_W-1:0] fl_way;
    logic             fl_adv, fl_last, flush_req, req, fl_wb;

    function automatic word_t blk_addr(input logic [TAG_W-1:0] t, input logic [SET_W-1:0] s);
        return {t, s, {(OFF_W + 2){1'b0}}};
    endfunction

    assign req       = ren || wen;
    assign fl_last   = fl_set == SET_W'(N_SETS - 1) && fl_way == WAY_W'(ASSOC - 1);
    assign fl_wb     = rd_valid[fl_way] && rd_dirty[fl_way];
    assign sel_set   = (state == CLEAR || state == FLUSH) ? fl_set : set_idx;
    assign ctrl_busy = state != READY;
    assign touch_way = hit_way;

    always_comb begin
        next_state   = state;
        fl_adv       = 1'b0;
        mem_ren      = 1'b0;
        mem_wen      = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_byte_en  = BE_NONE;
        wr_en        = 1'b0;
        wr_way       = fl_way;
        wr_valid     = 1'b0; // defaults give the clear form
        wr_dirty     = 1'b0;
        wr_tag       = '0;
        wr_block     = '0;
        wr_word_only = 1'b0;
        touch        = 1'b0;
        flush_done   = 1'b0;
        case (state)
            CLEAR: begin
                wr_en  = 1'b1;
                fl_adv = 1'b1;
                if (fl_last)
                    next_state = READY;
            end
            READY: begin
                touch = hit && req;
                if (write_hit) begin
                    wr_en        = 1'b1;
                    wr_way       = hit_way;
                    wr_word_only = 1'b1;
                end
                if (req) begin
                    if (pass_through) begin
                        mem_ren      = ren;
                        mem_wen      = wen;
                        mem_addr     = addr;
                        mem_wdata[0] = pass_store;
                        mem_byte_en  = byte_en;
                    end else if (!hit) begin
                        next_state = victim_dirty ? WB : FETCH;
                    end
                end else if (flush || flush_req) begin
                    next_state = FLUSH;
                end
            end
            WB: begin
                mem_wen     = 1'b1;
                mem_addr    = blk_addr(victim_tag, set_idx);
                mem_wdata   = rd_blocks[victim_way];
                mem_byte_en = BE_ALL;
                if (!mem_wait) begin // line leaves the cache once written
                    wr_en      = 1'b1;
                    wr_way     = victim_way;
                    wr_tag     = victim_tag;
                    wr_block   = rd_blocks[victim_way];
                    next_state = FETCH;
                end
            end
            FETCH: begin
                mem_ren     = 1'b1;
                mem_addr    = blk_addr(tag, set_idx);
                mem_byte_en = BE_ALL;
                if (!mem_wait) begin
                    wr_en      = 1'b1;
                    wr_way     = victim_way;
                    wr_tag     = tag;
                    wr_block   = mem_rdata;
                    wr_valid   = 1'b1;
                    next_state = READY;
                end
            end
            FLUSH: begin
                if (fl_wb) begin
                    mem_wen     = 1'b1;
                    mem_addr    = blk_addr(rd_tags[fl_way], fl_set);
                    mem_wdata   = rd_blocks[fl_way];
                    mem_byte_en = BE_ALL;
                end
                if (!fl_wb || !mem_wait) begin
                    wr_en  = 1'b1;
                    fl_adv = 1'b1;
                    if (fl_last) begin
                        flush_done = 1'b1;
                        next_state = READY;
                    end
                end
            end
            default: next_state = READY;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            fl_set    <= '0;
            fl_way    <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            flush_req <= (flush_req || flush) && !flush_done;
            if (fl_adv) begin
                if (fl_way == WAY_W'(ASSOC - 1)) begin
                    fl_way <= '0;
                    fl_set <= fl_set + 1'b1; // wraps to set 0 after the last one
                end else begin
                    fl_way <= fl_way + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/cache_arrays.sv ====
/* tag, valid, dirty and data storage, all ways of one set read combinationally
   only valid and dirty come out of reset, the controller wipes the rest */
`timescale 1ns/1ns

module cache_arrays import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    parameter int  ASSOC      = 2,
    localparam int N_SETS = CACHE_SIZE / 4 / BLOCK_SIZE / ASSOC,
    localparam int SET_W  = $clog2(N_SETS),
    localparam int OFF_W  = $clog2(BLOCK_SIZE),
    localparam int WAY_W  = (ASSOC > 1) ? $clog2(ASSOC) : 1,
    localparam int TAG_W  = WORD_W - SET_W - OFF_W - 2
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [SET_W-1:0]                  sel_set,
    input  logic                              wr_en,
    input  logic [WAY_W-1:0]                  wr_way,
    input  logic                              wr_valid,
    input  logic                              wr_dirty,
    input  logic [TAG_W-1:0]                  wr_tag,
    input  word_t [BLOCK_SIZE-1:0]            wr_block,
    input  logic                              wr_word_only, // single word store, sets dirty
    input  logic [OFF_W-1:0]                  wr_word_idx,
    input  word_t                             wr_word,
    output logic [ASSOC-1:0][TAG_W-1:0]       rd_tags,
    output logic [ASSOC-1:0]                  rd_valid,
    output logic [ASSOC-1:0]                  rd_dirty,
    output word_t [ASSOC-1:0][BLOCK_SIZE-1:0] rd_blocks
);

    logic [ASSOC-1:0][TAG_W-1:0]       tag_mem  [N_SETS];
    word_t [ASSOC-1:0][BLOCK_SIZE-1:0] data_mem [N_SETS];
    logic [N_SETS-1:0][ASSOC-1:0]      valid_mem, dirty_mem;

    assign rd_tags   = tag_mem[sel_set];
    assign rd_blocks = data_mem[sel_set];
    assign rd_valid  = valid_mem[sel_set];
    assign rd_dirty  = dirty_mem[sel_set];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else if (wr_en) begin
            if (wr_word_only) begin
                dirty_mem[sel_set][wr_way] <= 1'b1;
            end else begin
                valid_mem[sel_set][wr_way] <= wr_valid;
                dirty_mem[sel_set][wr_way] <= wr_dirty;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            if (wr_word_only) begin
                data_mem[sel_set][wr_way][wr_word_idx] <= wr_word;
            end else begin
                tag_mem[sel_set][wr_way]  <= wr_tag;
                data_mem[sel_set][wr_way] <= wr_block;
            end
        end
    end

endmodule

// ==== rtl/cache_lookup.sv ====
/* address split, tag compare and NRU victim choice
   hit is never raised for pass-through addresses */
`timescale 1ns/1ns

module cache_lookup import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE     = 1024,
    parameter int    BLOCK_SIZE     = 2,
    parameter int    ASSOC          = 2,
    parameter word_t NONCACHE_START = 32'h8000_0000,
    localparam int   N_SETS = CACHE_SIZE / 4 / BLOCK_SIZE / ASSOC,
    localparam int   SET_W  = $clog2(N_SETS),
    localparam int   OFF_W  = $clog2(BLOCK_SIZE),
    localparam int   WAY_W  = (ASSOC > 1) ? $clog2(ASSOC) : 1,
    localparam int   TAG_W  = WORD_W - SET_W - OFF_W - 2
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  word_t                       addr,
    input  logic [ASSOC-1:0][TAG_W-1:0] way_tags,
    input  logic [ASSOC-1:0]            way_valid,
    input  logic [ASSOC-1:0]            way_dirty,
    input  logic                        touch,
    input  logic [WAY_W-1:0]            touch_way,
    output logic [SET_W-1:0]            set_idx,
    output logic [TAG_W-1:0]            tag,
    output logic [OFF_W-1:0]            word_sel,
    output logic                        hit,
    output logic [WAY_W-1:0]            hit_way,
    output logic [WAY_W-1:0]            victim_way,
    output logic                        victim_dirty,
    output logic [TAG_W-1:0]            victim_tag,
    output logic                        pass_through
);

    logic [N_SETS-1:0][WAY_W-1:0] last_used; // per-set NRU way

    assign tag          = addr[WORD_W-1 -: TAG_W];
    assign set_idx      = addr[OFF_W+2 +: SET_W];
    assign word_sel     = addr[2 +: OFF_W];
    assign pass_through = addr >= NONCACHE_START;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (!pass_through && way_valid[i] && way_tags[i] == tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(i);
            end
        end
    end

    // victim is the way after the last used one
    always_comb begin
        if (ASSOC == 1 || last_used[set_idx] == WAY_W'(ASSOC - 1))
            victim_way = '0;
        else
            victim_way = last_used[set_idx] + 1'b1;
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = way_tags[victim_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            last_used <= '0;
        else if (touch)
            last_used[set_idx] <= touch_way;
    end

endmodule

// ==== rtl/l1_cache_pkg.sv ====
/* shared types for the L1 data cache
   word width is fixed at 32 bits with four byte lanes */

package l1_cache_pkg;

    localparam int WORD_W     = 32;
    localparam int BYTE_LANES = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;

    // byte enables for cached block traffic and an idle bus
    localparam logic [BYTE_LANES-1:0] BE_ALL  = '1;
    localparam logic [BYTE_LANES-1:0] BE_NONE = '0;

    // controller states
    typedef enum logic [2:0] {
        CLEAR, // array wipe after reset
        READY, // serving hits and pass-through
        FETCH, // block fill from memory
        WB,    // dirty victim write-back
        FLUSH  // write back all dirty lines, then clear
    } cache_state_t;

endpackage
